// File: design/board_macros.svh
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// ========================================
// Address map, byte addresses
// ========================================
`define ADDR_WIDTH    16
`define ROM_BASE      16'h0000
`define ROM_LIMIT     16'h1000
`define RAM_BASE      16'h1000
`define RAM_LIMIT     16'h3000
`define KEY_ADDR      16'h3000
`define STATUS_ADDR   16'h3004
`define UART_ADDR     16'h3008
`define IRQ_ACK_ADDR  16'h300C

// Memory sizes in 32-bit words
`define ROM_WORDS     1024
`define RAM_WORDS     2048
`define MEM_WORDS     (`ROM_WORDS + `RAM_WORDS)
// Word index width into the block RAM
`define MEM_AW        12

// Peripheral timing in CLOCK_50 cycles
`define UART_DIV      434
`define PS2_TIMEOUT   20000
`define BREAK_CODE    8'hF0

`endif

// File: design/board_pkg.sv
`default_nettype none

package board_pkg;

    // Decoded bus target
    typedef enum logic [2:0] {
        TGT_ROM,
        TGT_RAM,
        TGT_KEY,
        TGT_STATUS,
        TGT_UART,
        TGT_IRQ_ACK,
        TGT_NONE
    } bus_target_e;

    // PS/2 frame receive states
    typedef enum logic [1:0] {
        PS2_IDLE,
        PS2_DATA,
        PS2_PARITY,
        PS2_STOP
    } ps2_state_e;

    // Serial transmit states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_state_e;

endpackage

`default_nettype wire

// File: design/board_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module board_memory (
    input  logic              CLOCK_50,
    input  logic              sel,
    input  logic              we,
    input  logic [`MEM_AW-1:0] adr,
    input  logic [31:0]       wdata,
    output logic [31:0]       rdata,
    output logic              ack
);

    // ========================================
    // Block RAM, ROM words first then RAM
    // ========================================
    logic [31:0] mem [0:`MEM_WORDS-1];
    logic        in_ram;

    // Boot code goes at the bottom of the ROM region
    initial begin
        $readmemh("boot_rom.hex", mem, `ROM_BASE >> 2);
    end

    // Word index inside the writable part
    assign in_ram = (adr >= `ROM_WORDS) && (adr < `MEM_WORDS);

    // Single port, registered read
    always_ff @(posedge CLOCK_50) begin
        if (sel) begin
            rdata <= mem[adr];
        end
        // ROM writes simply fall through
        if (sel && we && in_ram) begin
            mem[adr] <= wdata;
        end
    end

    // ========================================
    // Acknowledge
    // ========================================
    // One wait cycle, then a single-cycle ack
    // Self-clearing while the master still holds stb
    always_ff @(posedge CLOCK_50) begin
        ack <= sel & ~ack;
    end

endmodule

`default_nettype wire

// File: design/ps2_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module ps2_receiver (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] scan_code,
    output logic       scan_valid
);

    // ========================================
    // Input synchronizers
    // ========================================
    logic       clk_meta;
    logic       clk_s;
    logic       clk_prev;
    logic       dat_meta;
    logic       dat_s;
    logic       fall;

    board_pkg::ps2_state_e state;
    logic [2:0]  bit_cnt;
    logic [7:0]  shift;
    logic        parity_ok;
    logic [15:0] idle_cnt;

    // Both lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_meta <= 1'b1;
            clk_s    <= 1'b1;
            clk_prev <= 1'b1;
            dat_meta <= 1'b1;
            dat_s    <= 1'b1;
        end else begin
            clk_meta <= ps2_clk;
            clk_s    <= clk_meta;
            clk_prev <= clk_s;
            dat_meta <= ps2_dat;
            dat_s    <= dat_meta;
        end
    end

    // Device changes data on rising edge, sample on falling
    assign fall = clk_prev & ~clk_s;

    // ========================================
    // Frame FSM
    // ========================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= board_pkg::PS2_IDLE;
            bit_cnt    <= 3'd0;
            parity_ok  <= 1'b0;
            idle_cnt   <= 16'd0;
            scan_valid <= 1'b0;
        end else begin
            scan_valid <= 1'b0;
            // Gap watchdog, only while inside a frame
            if (fall || state == board_pkg::PS2_IDLE) begin
                idle_cnt <= 16'd0;
            end else begin
                idle_cnt <= idle_cnt + 16'd1;
            end
            if (fall) begin
                case (state)
                    board_pkg::PS2_IDLE: begin
                        // Start bit must be low
                        if (!dat_s) begin
                            state   <= board_pkg::PS2_DATA;
                            bit_cnt <= 3'd0;
                        end
                    end
                    board_pkg::PS2_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= board_pkg::PS2_PARITY;
                        end
                    end
                    board_pkg::PS2_PARITY: begin
                        // Odd parity over data plus parity bit
                        parity_ok <= ^{shift, dat_s};
                        state     <= board_pkg::PS2_STOP;
                    end
                    default: begin
                        // Stop bit high and parity good, else drop it
                        if (dat_s && parity_ok) begin
                            scan_code  <= shift;
                            scan_valid <= 1'b1;
                        end
                        state <= board_pkg::PS2_IDLE;
                    end
                endcase
            end else if (idle_cnt == `PS2_TIMEOUT - 1) begin
                state <= board_pkg::PS2_IDLE;
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge CLOCK_50) begin
        if (fall && state == board_pkg::PS2_DATA) begin
            shift <= {dat_s, shift[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module uart_tx (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       uart_txd,
    output logic       tx_busy
);

    board_pkg::uart_state_e state;
    logic [8:0] div_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] shreg;
    logic       bit_done;

    // End of the current bit period
    assign bit_done = (div_cnt == `UART_DIV - 1);
    assign tx_busy  = (state != board_pkg::TX_IDLE);

    // ========================================
    // 8N1 transmit FSM
    // ========================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= board_pkg::TX_IDLE;
            div_cnt  <= 9'd0;
            bit_cnt  <= 3'd0;
            uart_txd <= 1'b1;
        end else begin
            if (state == board_pkg::TX_IDLE || bit_done) begin
                div_cnt <= 9'd0;
            end else begin
                div_cnt <= div_cnt + 9'd1;
            end
            case (state)
                board_pkg::TX_IDLE: begin
                    if (tx_start) begin
                        state    <= board_pkg::TX_START;
                        uart_txd <= 1'b0;
                    end
                end
                board_pkg::TX_START: begin
                    if (bit_done) begin
                        state    <= board_pkg::TX_DATA;
                        bit_cnt  <= 3'd0;
                        uart_txd <= shreg[0];
                    end
                end
                board_pkg::TX_DATA: begin
                    if (bit_done) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state    <= board_pkg::TX_STOP;
                            uart_txd <= 1'b1;
                        end else begin
                            // Next bit, shreg shifts on this same edge
                            uart_txd <= shreg[1];
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        state <= board_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    // Byte latch and LSB-first shifter
    always_ff @(posedge CLOCK_50) begin
        if (state == board_pkg::TX_IDLE && tx_start) begin
            shreg <= tx_data;
        end else if (state == board_pkg::TX_DATA && bit_done) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: design/bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module bus_fabric (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`ADDR_WIDTH-1:0] wb_adr,
    input  logic [31:0]            wb_dat_w,
    output logic [31:0]            wb_dat_r,
    output logic                   wb_ack,
    output logic                   mem_sel,
    output logic [`MEM_AW-1:0]     mem_adr,
    input  logic [31:0]            mem_rdata,
    input  logic                   mem_ack,
    input  logic [7:0]             scan_code,
    input  logic                   scan_valid,
    output logic                   tx_start,
    output logic [7:0]             tx_data,
    input  logic                   tx_busy,
    output logic [7:0]             key_code,
    output logic                   irq
);

    board_pkg::bus_target_e tgt;
    logic        req;
    logic        is_mem;
    logic        uart_wr;
    logic        accept;
    logic        fire;
    logic        reg_ack;
    logic [31:0] reg_rdata;
    logic        key_valid;
    logic        break_flag;

    // ========================================
    // Address decode
    // ========================================
    always_comb begin
        tgt = board_pkg::TGT_NONE;
        if (wb_adr < `ROM_LIMIT) begin
            tgt = board_pkg::TGT_ROM;
        end else if (wb_adr >= `RAM_BASE && wb_adr < `RAM_LIMIT) begin
            tgt = board_pkg::TGT_RAM;
        end else begin
            case (wb_adr)
                `KEY_ADDR:     tgt = board_pkg::TGT_KEY;
                `STATUS_ADDR:  tgt = board_pkg::TGT_STATUS;
                `UART_ADDR:    tgt = board_pkg::TGT_UART;
                `IRQ_ACK_ADDR: tgt = board_pkg::TGT_IRQ_ACK;
                default:       tgt = board_pkg::TGT_NONE;
            endcase
        end
    end

    assign req     = wb_cyc & wb_stb;
    assign is_mem  = (tgt == board_pkg::TGT_ROM) || (tgt == board_pkg::TGT_RAM);
    assign uart_wr = wb_we && (tgt == board_pkg::TGT_UART);

    // Memory answers on its own
    assign mem_sel = req & is_mem;
    assign mem_adr = wb_adr[`MEM_AW+1:2];

    // Register access, first cycle of stb only
    assign accept = req & ~reg_ack & ~is_mem & ~uart_wr;
    // UART write waits here until the transmitter is free
    assign fire   = req & uart_wr & ~tx_busy & ~reg_ack;

    // ========================================
    // Register side control
    // ========================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            reg_ack    <= 1'b0;
            tx_start   <= 1'b0;
            key_code   <= 8'h00;
            key_valid  <= 1'b0;
            break_flag <= 1'b0;
            irq        <= 1'b0;
        end else begin
            reg_ack  <= accept | fire;
            tx_start <= fire;
            // Reading KEY consumes the code
            if (accept && !wb_we && tgt == board_pkg::TGT_KEY) begin
                key_valid <= 1'b0;
            end
            if (accept && wb_we && tgt == board_pkg::TGT_IRQ_ACK) begin
                irq <= 1'b0;
            end
            // New key press wins over a same-cycle clear
            if (scan_valid) begin
                if (break_flag) begin
                    // Release code, swallowed
                    break_flag <= 1'b0;
                end else if (scan_code == `BREAK_CODE) begin
                    break_flag <= 1'b1;
                end else begin
                    key_code  <= scan_code;
                    key_valid <= 1'b1;
                    irq       <= 1'b1;
                end
            end
        end
    end

    // Read data and transmit byte
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            case (tgt)
                board_pkg::TGT_KEY:    reg_rdata <= {24'h0, key_code};
                board_pkg::TGT_STATUS: reg_rdata <= {29'h0, irq, tx_busy, key_valid};
                default:               reg_rdata <= 32'h0;
            endcase
        end
        if (fire) begin
            tx_data <= wb_dat_w[7:0];
        end
    end

    // ========================================
    // Response mux
    // ========================================
    assign wb_ack   = mem_ack | reg_ack;
    assign wb_dat_r = mem_ack ? mem_rdata : reg_rdata;

endmodule

`default_nettype wire

// File: design/cpu_on_board.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module cpu_on_board (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   PS2_CLK,
    input  logic                   PS2_DAT,
    // Wishbone classic, driven by the core
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`ADDR_WIDTH-1:0] wb_adr,
    input  logic [31:0]            wb_dat_w,
    output logic [31:0]            wb_dat_r,
    output logic                   wb_ack,
    // Board pins
    output logic [7:0]             LEDG,
    output logic                   LEDR0,
    output logic                   UART_TXD
);

    logic                mem_sel;
    logic [`MEM_AW-1:0]  mem_adr;
    logic [31:0]         mem_rdata;
    logic                mem_ack;
    logic [7:0]          scan_code;
    logic                scan_valid;
    logic                tx_start;
    logic [7:0]          tx_data;
    logic                tx_busy;
    logic [7:0]          key_code;
    logic                irq;

    // ========================================
    // Bus decoder and peripheral registers
    // ========================================
    bus_fabric bus_fabric_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .mem_sel    (mem_sel),
        .mem_adr    (mem_adr),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack),
        .scan_code  (scan_code),
        .scan_valid (scan_valid),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .tx_busy    (tx_busy),
        .key_code   (key_code),
        .irq        (irq)
    );

    // ROM plus RAM
    board_memory board_memory_i (
        .CLOCK_50 (CLOCK_50),
        .sel      (mem_sel),
        .we       (wb_we),
        .adr      (mem_adr),
        .wdata    (wb_dat_w),
        .rdata    (mem_rdata),
        .ack      (mem_ack)
    );

    // Keyboard port
    ps2_receiver ps2_receiver_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .ps2_clk    (PS2_CLK),
        .ps2_dat    (PS2_DAT),
        .scan_code  (scan_code),
        .scan_valid (scan_valid)
    );

    // Console output
    uart_tx uart_tx_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .uart_txd (UART_TXD),
        .tx_busy  (tx_busy)
    );

    // Debug LEDs
    assign LEDG  = key_code;
    assign LEDR0 = irq;

endmodule

`default_nettype wire

// File: verification/wb_master_tasks.svh
`ifndef WB_MASTER_TASKS_SVH
`define WB_MASTER_TASKS_SVH

// Long enough to cover a full serial frame of back-pressure
localparam int BUS_TIMEOUT = 12 * `UART_DIV;

// ========================================
// Wishbone classic master
// ========================================
// Request goes out on a falling edge and is held until ack
// Cycles counts falling edges from request to ack
task automatic write_word(input logic [15:0] adr, input logic [31:0] data,
                          output int cycles);
    @(negedge CLOCK_50);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    cycles   = 0;
    do begin
        @(negedge CLOCK_50);
        cycles++;
    end while (!wb_ack && cycles < BUS_TIMEOUT);
    if (!wb_ack) begin
        log_timeout($sformatf("bus write to %h got no ack", adr));
    end
    // Drop the strobe for the next cycle
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

// Read data is taken while ack is high
task automatic read_word(input logic [15:0] adr, output logic [31:0] data,
                         output int cycles);
    @(negedge CLOCK_50);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    cycles = 0;
    do begin
        @(negedge CLOCK_50);
        cycles++;
    end while (!wb_ack && cycles < BUS_TIMEOUT);
    if (!wb_ack) begin
        log_timeout($sformatf("bus read from %h got no ack", adr));
        data = 32'hx;
    end else begin
        data = wb_dat_r;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
endtask

`endif

// File: verification/cpu_on_board_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module cpu_on_board_tb;

    // PS/2 clock half period in system cycles
    // Far faster than a real keyboard
    localparam int PS2_HALF  = 20;
    localparam int IRQ_WAIT  = 50;
    localparam int UART_WAIT = 12 * `UART_DIV;

    logic        CLOCK_50;
    logic        KEY0;
    logic        PS2_CLK;
    logic        PS2_DAT;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [7:0]  LEDG;
    logic        LEDR0;
    logic        UART_TXD;

    int          mismatches;
    int          timeouts;
    int          lat;
    int          lat_second;
    int          frames_seen;
    int          n;
    int          idx;
    logic [31:0] rd;
    logic [31:0] wdata;
    logic [15:0] adr;
    logic [7:0]  tx_a;
    logic [7:0]  tx_b;
    logic [7:0]  rx_first;
    logic [7:0]  rx_second;
    logic [31:0] rom_ref [0:15];
    logic [31:0] ram_shadow [0:`RAM_WORDS-1];
    int          ram_used [$];

    cpu_on_board cpu_on_board_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .PS2_CLK  (PS2_CLK),
        .PS2_DAT  (PS2_DAT),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .LEDG     (LEDG),
        .LEDR0    (LEDR0),
        .UART_TXD (UART_TXD)
    );

    `include "wb_master_tasks.svh"

    // 4 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    // ========================================
    // Checking and reporting
    // ========================================
    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic report_and_finish();
        $display("Closing report: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic log_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        timeouts++;
    endtask

    // ========================================
    // PS/2 keyboard and serial line models
    // ========================================
    // Start, 8 data LSB first, odd parity, stop
    task automatic send_ps2_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        logic        parity;
        int          i;
        parity = ~^code;
        if (bad_parity) begin
            parity = ~parity;
        end
        frame = {1'b1, parity, code, 1'b0};
        for (i = 0; i < 11; i++) begin
            @(negedge CLOCK_50);
            PS2_DAT = frame[i];
            repeat (PS2_HALF / 2) @(negedge CLOCK_50);
            // Host samples on this falling edge
            PS2_CLK = 1'b0;
            repeat (PS2_HALF) @(negedge CLOCK_50);
            PS2_CLK = 1'b1;
            repeat (PS2_HALF / 2) @(negedge CLOCK_50);
        end
        PS2_DAT = 1'b1;
    endtask

    task automatic wait_for_irq(input logic level);
        int waited;
        waited = 0;
        while (LEDR0 !== level && waited < IRQ_WAIT) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (LEDR0 !== level) begin
            log_timeout($sformatf("irq never went to %b", level));
        end
    endtask

    // Samples each bit near its center
    task automatic capture_uart_byte(output logic [7:0] data);
        int waited;
        int i;
        waited = 0;
        data   = 8'h00;
        @(negedge CLOCK_50);
        while (UART_TXD !== 1'b0 && waited < UART_WAIT) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (UART_TXD !== 1'b0) begin
            log_timeout("no start bit on the serial line");
        end else begin
            repeat (`UART_DIV / 2) @(negedge CLOCK_50);
            expect_equal("UART start bit", {31'h0, UART_TXD}, 32'h0);
            for (i = 0; i < 8; i++) begin
                repeat (`UART_DIV) @(negedge CLOCK_50);
                data[i] = UART_TXD;
            end
            repeat (`UART_DIV) @(negedge CLOCK_50);
            expect_equal("UART stop bit", {31'h0, UART_TXD}, 32'h1);
        end
    endtask

    // ========================================
    // Scenarios
    // ========================================
    initial begin
        void'($urandom(32'hd8e1_7346));
        mismatches  = 0;
        timeouts    = 0;
        frames_seen = 0;
        KEY0     = 1'b0;
        PS2_CLK  = 1'b1;
        PS2_DAT  = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 16'h0;
        wb_dat_w = 32'h0;
        $readmemh("boot_rom.hex", rom_ref);

        repeat (5) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
        expect_equal("ack after reset", {31'h0, wb_ack}, 32'h0);
        expect_equal("irq after reset", {31'h0, LEDR0}, 32'h0);
        expect_equal("txd idle after reset", {31'h0, UART_TXD}, 32'h1);

        // ROM contents and one wait cycle per access
        for (n = 0; n < 16; n++) begin
            read_word(16'(n * 4), rd, lat);
            expect_equal($sformatf("ROM word %0d", n), rd, rom_ref[n]);
            expect_equal("ROM read latency", lat, 1);
        end
        write_word(16'h0008, ~rom_ref[2], lat);
        expect_equal("ROM write latency", lat, 1);
        read_word(16'h0008, rd, lat);
        expect_equal("ROM word after write", rd, rom_ref[2]);

        // Random RAM traffic against a shadow copy
        for (n = 0; n < 24; n++) begin
            idx   = $urandom % `RAM_WORDS;
            adr   = 16'(`RAM_BASE + idx * 4);
            wdata = $urandom;
            write_word(adr, wdata, lat);
            expect_equal("RAM write latency", lat, 1);
            ram_shadow[idx] = wdata;
            ram_used.push_back(idx);
        end
        for (n = 0; n < ram_used.size(); n++) begin
            idx = ram_used[n];
            read_word(16'(`RAM_BASE + idx * 4), rd, lat);
            expect_equal($sformatf("RAM word %0d", idx), rd, ram_shadow[idx]);
            expect_equal("RAM read latency", lat, 1);
        end

        // Holes in the map
        write_word(16'h3010, 32'hffff_ffff, lat);
        expect_equal("unmapped write latency", lat, 1);
        read_word(16'h3010, rd, lat);
        expect_equal("unmapped 0x3010", rd, 32'h0);
        read_word(16'hfffc, rd, lat);
        expect_equal("unmapped 0xfffc", rd, 32'h0);
        expect_equal("unmapped read latency", lat, 1);

        // Key press then consume it
        send_ps2_frame(8'h1c, 1'b0);
        wait_for_irq(1'b1);
        read_word(`STATUS_ADDR, rd, lat);
        expect_equal("STATUS after press", rd, 32'h5);
        expect_equal("STATUS latency", lat, 1);
        read_word(`KEY_ADDR, rd, lat);
        expect_equal("KEY code", rd, 32'h1c);
        expect_equal("KEY latency", lat, 1);
        expect_equal("LEDG code", {24'h0, LEDG}, 32'h1c);
        read_word(`STATUS_ADDR, rd, lat);
        expect_equal("STATUS after KEY read", rd, 32'h4);

        // Acknowledge drops the line
        write_word(`IRQ_ACK_ADDR, 32'h1, lat);
        expect_equal("IRQ_ACK latency", lat, 1);
        expect_equal("irq after ack", {31'h0, LEDR0}, 32'h0);

        // Release sequence is swallowed
        send_ps2_frame(`BREAK_CODE, 1'b0);
        send_ps2_frame(8'h32, 1'b0);
        repeat (10) @(negedge CLOCK_50);
        expect_equal("irq after release", {31'h0, LEDR0}, 32'h0);
        expect_equal("LEDG after release", {24'h0, LEDG}, 32'h1c);
        read_word(`STATUS_ADDR, rd, lat);
        expect_equal("STATUS after release", rd, 32'h0);

        // Corrupted parity is ignored
        send_ps2_frame(8'h2b, 1'b1);
        repeat (10) @(negedge CLOCK_50);
        expect_equal("irq after bad parity", {31'h0, LEDR0}, 32'h0);
        expect_equal("LEDG after bad parity", {24'h0, LEDG}, 32'h1c);

        // Receiver still takes a clean frame afterwards
        send_ps2_frame(8'h2b, 1'b0);
        wait_for_irq(1'b1);
        expect_equal("LEDG after recovery", {24'h0, LEDG}, 32'h2b);
        write_word(`IRQ_ACK_ADDR, 32'h1, lat);
        expect_equal("irq after second ack", {31'h0, LEDR0}, 32'h0);

        // Two back-to-back console bytes
        tx_a = 8'($urandom);
        tx_b = 8'($urandom);
        fork
            begin
                capture_uart_byte(rx_first);
                frames_seen = 1;
                capture_uart_byte(rx_second);
                frames_seen = 2;
            end
            begin
                write_word(`UART_ADDR, {24'h0, tx_a}, lat);
                expect_equal("first UART write latency", lat, 1);
                write_word(`UART_ADDR, {24'h0, tx_b}, lat_second);
                // First frame must be over before the second is taken
                expect_equal("frames done at second ack", frames_seen, 1);
                // Busy spans ten bit periods from the first start bit
                assert (lat_second >= 10 * `UART_DIV - 4 && lat_second <= 10 * `UART_DIV + 4)
                else begin
                    $display("MISMATCH at %0t: UART back-pressure latency %0d out of range",
                             $time, lat_second);
                    mismatches++;
                end
            end
        join
        expect_equal("first serial byte", {24'h0, rx_first}, {24'h0, tx_a});
        expect_equal("second serial byte", {24'h0, rx_second}, {24'h0, tx_b});

        report_and_finish();
    end

endmodule

`default_nettype wire

// File: boot_rom.hex
// Boot ROM image: one 32-bit word per line in hex, word 0 first
// Loaded at byte address 0x0000 of the ROM region
00001137
000030b7
0040a183
0011f193
fe018ce3
0000a203
00400293
00520463
0060a423
0082a023
00128293
fe5ff06f
00000013
0000006f
00100073
0ff0000f

// File: cpu_on_board.f
+incdir+design
+incdir+verification
design/board_pkg.sv
design/board_memory.sv
design/ps2_receiver.sv
design/uart_tx.sv
design/bus_fabric.sv
design/cpu_on_board.sv
verification/cpu_on_board_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the board testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module cpu_on_board_tb \
    -f cpu_on_board.f \
    -o cpu_on_board_sim

./obj_dir/cpu_on_board_sim | tee "$LOG"

# The testbench prints its verdict into the log
if grep -q "Some tests failed" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"
